//--- hdl/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [5:0]  prescale_t;
    typedef logic [4:0]  dummy_t;
    typedef logic [4:0]  size_t;

    typedef enum logic [1:0] {
        LANE_NONE,
        LANE_X1,
        LANE_X2,
        LANE_X4
    } lane_mode_e;

    // Control register, listed from bit 31 down to bit 0
    typedef struct packed {
        logic       start;
        prescale_t  prescale;
        logic [2:0] spare;
        logic       addr_en;
        size_t      size;
        dummy_t     dummy;
        logic       write;
        lane_mode_e mode;
        logic [7:0] cmd;
    } ccr_t;

    typedef struct packed {
        logic     read;
        logic     write;
        reg_idx_t idx;
        byte_en_t be;
        word_t    wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR,
        ST_DUMMY,
        ST_DATA,
        ST_FETCH,
        ST_STORE,
        ST_END
    } engine_state_e;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam int       DR_WORDS = 8;
    localparam reg_idx_t REG_CCR  = 4'd0;
    localparam reg_idx_t REG_ADR  = 4'd1;
    localparam reg_idx_t REG_DR0  = 4'd2;
    localparam reg_idx_t REG_STA  = REG_DR0 + 4'(DR_WORDS);
    localparam int       NUM_REGS = int'(REG_STA) + 1;

    // Status words written by the engine, busy in bit 0 and done in bit 1
    localparam word_t STA_BUSY = 32'h0000_0001;
    localparam word_t STA_DONE = 32'h0000_0002;

endpackage

`default_nettype wire

//--- hdl/qspi_reg_file.sv
`default_nettype none

module qspi_reg_file (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire qspi_pkg::mem_req_t req_i,
    output qspi_pkg::word_t         rdata_o,
    output qspi_pkg::ccr_t          ccr_o,
    output logic [23:0]             addr_o,
    output logic                    ccr_wr_o
);
    import qspi_pkg::*;

    word_t regs [NUM_REGS];
    word_t rdata_q;
    logic  ccr_wr_q;
    logic  in_range;

    // Indices 11 to 15 are holes in the map
    assign in_range = int'(req_i.idx) < NUM_REGS;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (req_i.write && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    regs[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read port holds its last word between reads
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (req_i.read) begin
            rdata_q <= in_range ? regs[req_i.idx] : '0;
        end
    end

    // The start bit lives in byte 3, so only a write of that byte can launch a transfer
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ccr_wr_q <= 1'b0;
        end else begin
            ccr_wr_q <= req_i.write && req_i.idx == REG_CCR && req_i.be[3];
        end
    end

    assign rdata_o  = rdata_q;
    assign ccr_o    = ccr_t'(regs[REG_CCR]);
    assign addr_o   = regs[REG_ADR][23:0];
    assign ccr_wr_o = ccr_wr_q;

endmodule

`default_nettype wire

//--- hdl/qspi_mem_arbiter.sv
`default_nettype none

module qspi_mem_arbiter (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire qspi_pkg::mem_req_t host_req_i,
    input  wire qspi_pkg::mem_req_t eng_req_i,
    output logic                    host_ccr_o,
    output qspi_pkg::mem_req_t      mem_req_o,
    output logic                    eng_gnt_o
);
    import qspi_pkg::*;

    logic host_sel;
    logic eng_act;
    logic host_ccr_q;

    // The host never waits, any strobe takes the port
    assign host_sel = host_req_i.read || host_req_i.write;
    assign eng_act  = eng_req_i.read || eng_req_i.write;

    assign mem_req_o = host_sel ? host_req_i : eng_req_i;
    assign eng_gnt_o = !host_sel && eng_act;

    // Tags the CCR update of the last cycle as coming from the host side,
    // lines up with the write pulse of the register file
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            host_ccr_q <= 1'b0;
        end else begin
            host_ccr_q <= host_req_i.write && host_req_i.idx == REG_CCR;
        end
    end

    assign host_ccr_o = host_ccr_q;

endmodule

`default_nettype wire

//--- hdl/qspi_sclk_gen.sv
`default_nettype none

module qspi_sclk_gen (
    input  wire                      clk_i,
    input  wire                      arst_n_i,
    input  wire                      run_i,
    input  wire                      pause_i,
    input  wire qspi_pkg::prescale_t prescale_i,
    output logic                     sclk_o,
    output logic                     rise_o,
    output logic                     fall_o
);
    import qspi_pkg::*;

    prescale_t cnt_q;
    logic      sclk_q;
    logic      tick;

    // Half period ends after prescale + 1 active cycles
    assign tick = run_i && !pause_i && cnt_q == prescale_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            sclk_q <= 1'b0;
        end else if (!run_i) begin
            cnt_q  <= '0;
            sclk_q <= 1'b0;
        end else if (!pause_i) begin
            if (tick) begin
                cnt_q  <= '0;
                sclk_q <= !sclk_q;
            end else begin
                cnt_q <= cnt_q + 6'd1;
            end
        end
    end

    // Strobes lead the clock edge they announce by one cycle
    assign rise_o = tick && !sclk_q;
    assign fall_o = tick && sclk_q;
    assign sclk_o = sclk_q;

endmodule

`default_nettype wire

//--- hdl/qspi_shift_engine.sv
`default_nettype none

module qspi_shift_engine (
    input  wire                      clk_i,
    input  wire                      arst_n_i,
    input  wire qspi_pkg::ccr_t      ccr_i,
    input  wire [23:0]               addr_i,
    input  wire                      ccr_wr_i,
    output qspi_pkg::mem_req_t       req_o,
    input  wire                      gnt_i,
    input  wire qspi_pkg::word_t     rdata_i,
    input  wire                      rise_i,
    input  wire                      fall_i,
    output logic                     run_o,
    output logic                     pause_o,
    output qspi_pkg::prescale_t      prescale_o,
    output logic                     cs_n_o,
    output logic [3:0]               io_o,
    output logic [3:0]               io_oe_o,
    input  wire [3:0]                io_i,
    output logic                     done_o
);
    import qspi_pkg::*;

    engine_state_e state_q;
    engine_state_e cmd_st;
    engine_state_e addr_st;
    engine_state_e data_st;
    ccr_t          cfg_q;
    logic [31:0]   sh_q;
    word_t         dr_q;
    logic [4:0]    cnt_q;
    logic [8:0]    bit_q;
    logic          sta_pend_q;
    logic          rd_pend_q;
    logic          done_q;
    logic          start;
    logic          own_gnt;
    logic [2:0]    step;
    logic [8:0]    tot_bits;
    logic [8:0]    bit_nxt;
    logic [8:0]    bit_last;
    byte_en_t      last_be;
    logic [3:0]    lanes_out;
    logic [3:0]    lanes_in;
    logic [4:0]    pos [4];

    assign start    = ccr_wr_i && ccr_i.start && state_q == ST_IDLE;
    assign own_gnt  = gnt_i && !sta_pend_q;
    assign tot_bits = ({4'd0, cfg_q.size} + 9'd1) << 3;
    assign bit_nxt  = bit_q + {6'd0, step};
    assign bit_last = bit_q - 9'd1;

    //////////////////////////////
    // Phase sequencing
    //////////////////////////////

    assign data_st = (cfg_q.mode == LANE_NONE) ? ST_END :
                     cfg_q.write ? ST_FETCH : ST_DATA;
    assign addr_st = (cfg_q.dummy != '0) ? ST_DUMMY : data_st;
    assign cmd_st  = cfg_q.addr_en ? ST_ADDR : addr_st;

    always_comb begin
        case (cfg_q.mode)
            LANE_X2: step = 3'd2;
            LANE_X4: step = 3'd4;
            default: step = 3'd1;
        endcase
    end

    // Bit j of the current clock sits at this position of the data word,
    // byte lane from bits 4:3 and MSB first inside the byte
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            pos[j]          = {bit_q[4:3], ~bit_q[2:0] - 3'(j)};
            lanes_out[3 - j] = dr_q[pos[j]];
        end
    end

    always_comb begin
        case (cfg_q.mode)
            LANE_X1: lanes_in = {io_i[1], 3'b000};
            LANE_X2: lanes_in = {io_i[1:0], 2'b00};
            default: lanes_in = io_i;
        endcase
    end

    // Final word of a read may be partial
    always_comb begin
        case (bit_q[4:3])
            2'd1:    last_be = 4'b0001;
            2'd2:    last_be = 4'b0011;
            2'd3:    last_be = 4'b0111;
            default: last_be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            bit_q      <= '0;
            sta_pend_q <= 1'b0;
            rd_pend_q  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (sta_pend_q && gnt_i) begin
                sta_pend_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q    <= ST_CMD;
                        cnt_q      <= 5'd7;
                        bit_q      <= '0;
                        sta_pend_q <= 1'b1;
                    end
                end
                ST_CMD: begin
                    if (fall_i) begin
                        cnt_q <= cnt_q - 5'd1;
                        if (cnt_q == '0) begin
                            state_q <= cmd_st;
                            cnt_q   <= cfg_q.addr_en ? 5'd23 : cfg_q.dummy - 5'd1;
                        end
                    end
                end
                ST_ADDR: begin
                    if (fall_i) begin
                        cnt_q <= cnt_q - 5'd1;
                        if (cnt_q == '0) begin
                            state_q <= addr_st;
                            cnt_q   <= cfg_q.dummy - 5'd1;
                        end
                    end
                end
                ST_DUMMY: begin
                    if (fall_i) begin
                        cnt_q <= cnt_q - 5'd1;
                        if (cnt_q == '0) begin
                            state_q <= data_st;
                        end
                    end
                end
                ST_DATA: begin
                    if (fall_i) begin
                        bit_q <= bit_nxt;
                        if (bit_nxt == tot_bits) begin
                            state_q <= cfg_q.write ? ST_END : ST_STORE;
                        end else if (bit_nxt[4:0] == '0) begin
                            state_q <= cfg_q.write ? ST_FETCH : ST_STORE;
                        end
                    end
                end
                ST_FETCH: begin
                    if (own_gnt) begin
                        rd_pend_q <= 1'b1;
                    end
                    if (rd_pend_q) begin
                        rd_pend_q <= 1'b0;
                        state_q   <= ST_DATA;
                    end
                end
                ST_STORE: begin
                    if (own_gnt) begin
                        state_q <= (bit_q == tot_bits) ? ST_END : ST_DATA;
                    end
                end
                ST_END: begin
                    if (own_gnt) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command and address leave through one shift register, data is
    // picked from and placed into the data word by position
    always_ff @(posedge clk_i) begin
        if (start) begin
            cfg_q <= ccr_i;
            sh_q  <= {ccr_i.cmd, addr_i};
        end else if ((state_q == ST_CMD || state_q == ST_ADDR) && fall_i) begin
            sh_q <= sh_q << 1;
        end
        if (state_q == ST_FETCH && rd_pend_q) begin
            dr_q <= rdata_i;
        end else if (state_q == ST_DATA && rise_i && !cfg_q.write) begin
            for (int j = 0; j < 4; j++) begin
                if (j < int'(step)) begin
                    dr_q[pos[j]] <= lanes_in[3 - j];
                end
            end
        end
    end

    //////////////////////////////
    // Register file requests
    //////////////////////////////

    always_comb begin
        req_o = '0;
        if (sta_pend_q) begin
            req_o.write = 1'b1;
            req_o.idx   = REG_STA;
            req_o.be    = 4'hf;
            req_o.wdata = STA_BUSY;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    req_o.read = !rd_pend_q;
                    req_o.idx  = REG_DR0 + {1'b0, bit_q[7:5]};
                    req_o.be   = 4'hf;
                end
                ST_STORE: begin
                    req_o.write = 1'b1;
                    req_o.idx   = REG_DR0 + {1'b0, bit_last[7:5]};
                    req_o.be    = last_be;
                    req_o.wdata = dr_q;
                end
                ST_END: begin
                    req_o.write = 1'b1;
                    req_o.idx   = REG_STA;
                    req_o.be    = 4'hf;
                    req_o.wdata = STA_DONE;
                end
                default: req_o = '0;
            endcase
        end
    end

    always_comb begin
        io_o    = 4'b0000;
        io_oe_o = 4'b0000;
        case (state_q)
            ST_CMD, ST_ADDR: begin
                io_o[0]    = sh_q[31];
                io_oe_o[0] = 1'b1;
            end
            ST_DATA, ST_FETCH: begin
                if (cfg_q.write) begin
                    case (cfg_q.mode)
                        LANE_X2: begin
                            io_o    = {2'b00, lanes_out[3:2]};
                            io_oe_o = 4'b0011;
                        end
                        LANE_X4: begin
                            io_o    = lanes_out;
                            io_oe_o = 4'b1111;
                        end
                        default: begin
                            io_o    = {3'b000, lanes_out[3]};
                            io_oe_o = 4'b0001;
                        end
                    endcase
                end
            end
            default: io_oe_o = 4'b0000;
        endcase
    end

    // Flash clock stops while a data word waits on the register file
    assign pause_o    = state_q == ST_FETCH || state_q == ST_STORE;
    assign cs_n_o     = state_q == ST_IDLE || state_q == ST_END;
    assign run_o      = !cs_n_o;
    assign prescale_o = cfg_q.prescale;
    assign done_o     = done_q;

endmodule

`default_nettype wire

//--- hdl/qspi_master.sv
`default_nettype none

module qspi_master (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     write_i,
    input  wire                     read_i,
    input  wire qspi_pkg::byte_en_t be_i,
    input  wire [5:0]               addr_i,
    input  wire qspi_pkg::word_t    wdata_i,
    output qspi_pkg::word_t         rdata_o,
    output logic                    done_o,
    output logic                    sclk_o,
    output logic                    cs_n_o,
    inout  wire [3:0]               io
);
    import qspi_pkg::*;

    mem_req_t    host_req;
    mem_req_t    eng_req;
    mem_req_t    mem_req;
    word_t       rdata;
    ccr_t        ccr;
    logic [23:0] flash_addr;
    logic        ccr_wr;
    logic        host_ccr;
    logic        eng_gnt;
    logic        run;
    logic        pause;
    logic        rise;
    logic        fall;
    prescale_t   prescale;
    logic [3:0]  io_out;
    logic [3:0]  io_oe;

    // Word index from the byte address, bits 1:0 select nothing
    assign host_req = '{read: read_i, write: write_i, idx: addr_i[5:2],
                        be: be_i, wdata: wdata_i};

    qspi_mem_arbiter arbiter_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .host_req_i (host_req),
        .eng_req_i  (eng_req),
        .host_ccr_o (host_ccr),
        .mem_req_o  (mem_req),
        .eng_gnt_o  (eng_gnt)
    );

    qspi_reg_file reg_file_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (mem_req),
        .rdata_o  (rdata),
        .ccr_o    (ccr),
        .addr_o   (flash_addr),
        .ccr_wr_o (ccr_wr)
    );

    qspi_sclk_gen sclk_gen_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .run_i      (run),
        .pause_i    (pause),
        .prescale_i (prescale),
        .sclk_o     (sclk_o),
        .rise_o     (rise),
        .fall_o     (fall)
    );

    qspi_shift_engine engine_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ccr_i      (ccr),
        .addr_i     (flash_addr),
        .ccr_wr_i   (ccr_wr && host_ccr),
        .req_o      (eng_req),
        .gnt_i      (eng_gnt),
        .rdata_i    (rdata),
        .rise_i     (rise),
        .fall_i     (fall),
        .run_o      (run),
        .pause_o    (pause),
        .prescale_o (prescale),
        .cs_n_o     (cs_n_o),
        .io_o       (io_out),
        .io_oe_o    (io_oe),
        .io_i       (io),
        .done_o     (done_o)
    );

    for (genvar i = 0; i < 4; i++) begin : g_io
        assign io[i] = io_oe[i] ? io_out[i] : 1'bz;
    end

    assign rdata_o = rdata;

endmodule

`default_nettype wire

//--- tests/qspi_flash_model.sv
`default_nettype none

module qspi_flash_model (
    input  wire       sclk_i,
    input  wire       cs_n_i,
    inout  wire [3:0] io
);
    logic [7:0]  cmd_q;
    logic [23:0] addr_q;
    logic [7:0]  sh_byte;
    logic [7:0]  wr_mem [64];
    logic [3:0]  drv_q;
    logic [3:0]  oe_q;
    int          sh_bits;
    int          txn_cnt;
    int          rise_cnt;
    int          wr_cnt;

    // Command set known to the model
    function automatic int lanes_of(input logic [7:0] c);
        case (c)
            8'h0B, 8'h02: return 1;
            8'hA2:        return 2;
            8'h6B, 8'h32: return 4;
            default:      return 0;
        endcase
    endfunction

    function automatic bit is_read(input logic [7:0] c);
        return c == 8'h0B || c == 8'h6B;
    endfunction

    // Clocks before the first data bit: command, address and dummy
    function automatic int hdr_len(input logic [7:0] c);
        return 8 + ((c == 8'h06) ? 0 : 24) + (is_read(c) ? 8 : 0);
    endfunction

    function automatic logic [7:0] read_byte(input int n);
        logic [31:0] v;
        v = (32'(addr_q) + 32'(n)) * 7 + 3;
        return v[7:0];
    endfunction

    initial begin
        oe_q     = 4'b0000;
        drv_q    = 4'b0000;
        txn_cnt  = 0;
        rise_cnt = 0;
        wr_cnt   = 0;
        sh_bits  = 0;
    end

    always @(negedge cs_n_i) begin
        txn_cnt  = txn_cnt + 1;
        rise_cnt = 0;
        wr_cnt   = 0;
        sh_bits  = 0;
        cmd_q    = '0;
        addr_q   = '0;
    end

    always @(posedge cs_n_i) begin
        oe_q = 4'b0000;
    end

    // Mode 0, inputs are taken on the rising flash clock
    always @(posedge sclk_i) begin
        if (!cs_n_i) begin
            if (rise_cnt < 8) begin
                cmd_q = {cmd_q[6:0], io[0]};
            end else if (cmd_q != 8'h06 && rise_cnt < 32) begin
                addr_q = {addr_q[22:0], io[0]};
            end else if (rise_cnt >= hdr_len(cmd_q) && !is_read(cmd_q)) begin
                case (lanes_of(cmd_q))
                    1: sh_byte = {sh_byte[6:0], io[0]};
                    2: sh_byte = {sh_byte[5:0], io[1], io[0]};
                    4: sh_byte = {sh_byte[3:0], io};
                    default: sh_byte = sh_byte;
                endcase
                sh_bits = sh_bits + lanes_of(cmd_q);
                if (sh_bits >= 8 && wr_cnt < 64) begin
                    wr_mem[wr_cnt] = sh_byte;
                    wr_cnt         = wr_cnt + 1;
                    sh_bits        = 0;
                end
            end
            rise_cnt = rise_cnt + 1;
        end
    end

    // Read data changes on the falling flash clock, first bit on the top lane
    always @(negedge sclk_i) begin
        int         idx;
        int         top;
        logic [7:0] data;
        if (!cs_n_i && rise_cnt >= 8 && is_read(cmd_q) && rise_cnt >= hdr_len(cmd_q)) begin
            idx  = (rise_cnt - hdr_len(cmd_q)) * lanes_of(cmd_q);
            data = read_byte(idx / 8);
            top  = (lanes_of(cmd_q) == 4) ? 3 : 1;
            oe_q = (lanes_of(cmd_q) == 4) ? 4'b1111 : 4'b0010;
            for (int j = 0; j < lanes_of(cmd_q); j++) begin
                drv_q[top - j] = data[7 - (idx % 8) - j];
            end
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_drv
        assign io[i] = oe_q[i] ? drv_q[i] : 1'bz;
    end

endmodule

`default_nettype wire

//--- tests/tb_qspi_master.sv
`default_nettype none

module tb_qspi_master;
    import qspi_pkg::*;

    localparam int        CLK_PERIOD = 40;
    localparam prescale_t PRESCALE   = 6'd1;
    // Longest transaction in flash clocks plus slack for register file stalls
    localparam int        TXN_CYCLES = (8 + 24 + 31 + 256) * 2 * (int'(PRESCALE) + 1) + 300;
    localparam int        RUN_LIMIT  = (8 * TXN_CYCLES + 1000) * CLK_PERIOD;

    logic        clk_i;
    logic        arst_n_i;
    logic        write_i;
    logic        read_i;
    byte_en_t    be_i;
    logic [5:0]  addr_i;
    word_t       wdata_i;
    word_t       rdata_o;
    logic        done_o;
    logic        sclk_o;
    logic        cs_n_o;
    wire  [3:0]  io;
    logic [31:0] lfsr_q;
    word_t       shadow [NUM_REGS];
    int          done_cnt;

    qspi_master qspi_master_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .write_i  (write_i),
        .read_i   (read_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rdata_o  (rdata_o),
        .done_o   (done_o),
        .sclk_o   (sclk_o),
        .cs_n_o   (cs_n_o),
        .io       (io)
    );

    qspi_flash_model flash_i (
        .sclk_i (sclk_o),
        .cs_n_i (cs_n_o),
        .io     (io)
    );

    for (genvar i = 0; i < 4; i++) begin : g_pull
        pullup (io[i]);
    end

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = !clk_i;
    end

    initial begin
        done_cnt = 0;
    end

    always @(negedge clk_i) begin
        if (done_o) begin
            done_cnt = done_cnt + 1;
        end
    end

    initial begin
        #(RUN_LIMIT);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $fatal(1);
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input int idx, input byte_en_t be, input word_t data);
        write_i = 1'b1;
        be_i    = be;
        addr_i  = 6'(idx << 2);
        wdata_i = data;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        @(posedge clk_i);
        #5;
        write_i = 1'b0;
    endtask

    task automatic read_reg(input int idx, output word_t data);
        read_i = 1'b1;
        addr_i = 6'(idx << 2);
        @(posedge clk_i);
        #5;
        read_i = 1'b0;
        data   = rdata_o;
    endtask

    task automatic start_txn(input logic [7:0] cmd, input lane_mode_e mode, input logic wr,
                             input int dummy, input int size, input logic addr_en);
        ccr_t c;
        c          = '0;
        c.cmd      = cmd;
        c.mode     = mode;
        c.write    = wr;
        c.dummy    = dummy_t'(dummy);
        c.size     = size_t'(size);
        c.addr_en  = addr_en;
        c.prescale = PRESCALE;
        c.start    = 1'b1;
        write_reg(REG_CCR, 4'hf, word_t'(c));
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o) begin
            if (n >= TXN_CYCLES) begin
                $display("Timed out waiting for the end of a transaction");
                $display("Result: FAILED");
                $fatal(1);
            end
            @(posedge clk_i);
            #5;
            n++;
        end
        @(posedge clk_i);
        #5;
    endtask

    function automatic logic [7:0] pattern(input logic [23:0] a, input int n);
        logic [31:0] v;
        v = (32'(a) + 32'(n)) * 7 + 3;
        return v[7:0];
    endfunction

    task automatic check_read_data(input logic [23:0] a, input int nbytes);
        word_t w;
        for (int k = 0; k < nbytes; k++) begin
            if (k % 4 == 0) begin
                read_reg(REG_DR0 + k / 4, w);
            end
            check_eq(w[8*(k%4) +: 8], pattern(a, k), $sformatf("read byte %0d", k));
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_registers();
        word_t    w;
        word_t    data;
        byte_en_t be;
        check_eq(cs_n_o, 1'b1, "chip select after reset");
        check_eq(sclk_o, 1'b0, "flash clock after reset");
        check_eq(done_o, 1'b0, "done after reset");
        check_eq(io, 4'hf, "io lines after reset");
        read_reg(REG_STA, w);
        check_eq(w, 32'h0, "STA after reset");
        for (int r = 0; r < int'(REG_STA); r++) begin
            for (int n = 0; n < 2; n++) begin
                data = rand_bits(32);
                be   = byte_en_t'(rand_bits(4));
                // Keep the start bit clear so no transfer is launched
                if (r == int'(REG_CCR)) begin
                    data[31] = 1'b0;
                end
                write_reg(r, be, data);
            end
            read_reg(r, w);
            check_eq(w, shadow[r], $sformatf("register %0d readback", r));
        end
    endtask

    task automatic test_cmd_only();
        int  t0;
        int  d0;
        time t_rise;
        t0 = flash_i.txn_cnt;
        d0 = done_cnt;
        start_txn(8'h06, LANE_NONE, 1'b0, 0, 0, 1'b0);
        @(posedge sclk_o);
        t_rise = $time;
        @(posedge sclk_o);
        #5;
        check_eq(32'($time - 5 - t_rise), 2 * (int'(PRESCALE) + 1) * CLK_PERIOD,
                 "flash clock period");
        wait_done();
        check_eq(flash_i.cmd_q, 8'h06, "command byte");
        check_eq(flash_i.rise_cnt, 8, "command only clock count");
        check_eq(flash_i.wr_cnt, 0, "command only data bytes");
        check_eq(flash_i.txn_cnt, t0 + 1, "command only transactions");
        check_eq(done_cnt, d0 + 1, "done pulses");
        check_eq(done_o, 1'b0, "done pulse width");
        check_eq(cs_n_o, 1'b1, "chip select after done");
    endtask

    task automatic test_single_read();
        logic [23:0] a;
        a = 24'(rand_bits(24));
        write_reg(REG_ADR, 4'hf, {8'h00, a});
        start_txn(8'h0B, LANE_X1, 1'b0, 8, 11, 1'b1);
        wait_done();
        check_eq(flash_i.addr_q, a, "single read address");
        check_eq(flash_i.rise_cnt - 8 - 24 - 8 * 12, 8, "dummy clocks");
        check_read_data(a, 12);
    endtask

    task automatic test_write(input logic [7:0] cmd, input lane_mode_e mode);
        logic [23:0] a;
        int          size;
        size = int'(rand_bits(5));
        a    = 24'(rand_bits(24));
        for (int w = 0; w < DR_WORDS; w++) begin
            write_reg(REG_DR0 + w, 4'hf, rand_bits(32));
        end
        write_reg(REG_ADR, 4'hf, {8'h00, a});
        start_txn(cmd, mode, 1'b1, 0, size, 1'b1);
        wait_done();
        check_eq(flash_i.cmd_q, cmd, "write command");
        check_eq(flash_i.addr_q, a, "write address");
        check_eq(flash_i.wr_cnt, size + 1, "written byte count");
        for (int k = 0; k <= size; k++) begin
            check_eq(flash_i.wr_mem[k], shadow[REG_DR0 + k / 4][8*(k%4) +: 8],
                     $sformatf("written byte %0d", k));
        end
    endtask

    task automatic test_quad_read_polled();
        logic [23:0] a;
        word_t       sta;
        int          busy_seen;
        int          n;
        bit          finished;
        a         = 24'(rand_bits(24));
        busy_seen = 0;
        n         = 0;
        finished  = 0;
        write_reg(REG_ADR, 4'hf, {8'h00, a});
        start_txn(8'h6B, LANE_X4, 1'b0, 8, 31, 1'b1);
        // Status is read every other cycle so the engine only gets the gaps
        while (!finished) begin
            read_reg(REG_STA, sta);
            if (sta[0]) begin
                busy_seen++;
            end
            finished = done_o;
            @(posedge clk_i);
            #5;
            finished = finished || done_o;
            n += 2;
            if (n > TXN_CYCLES) begin
                $display("Quad read did not finish under host polling");
                $display("Result: FAILED");
                $fatal(1);
            end
        end
        @(posedge clk_i);
        #5;
        check_eq(busy_seen != 0, 1, "busy seen during transfer");
        read_reg(REG_STA, sta);
        check_eq(sta, 32'h0000_0002, "STA after transfer");
        check_read_data(a, 32);
    endtask

    task automatic test_busy_restart();
        int t0;
        int d0;
        t0 = flash_i.txn_cnt;
        d0 = done_cnt;
        start_txn(8'h32, LANE_X4, 1'b1, 0, 31, 1'b1);
        repeat (10) @(posedge clk_i);
        #5;
        check_eq(cs_n_o, 1'b0, "busy before second start");
        start_txn(8'h32, LANE_X4, 1'b1, 0, 31, 1'b1);
        wait_done();
        repeat (50) @(posedge clk_i);
        #5;
        check_eq(flash_i.txn_cnt, t0 + 1, "transactions after restart while busy");
        check_eq(flash_i.wr_cnt, 32, "bytes written with a restart while busy");
        check_eq(done_cnt, d0 + 1, "done pulses after restart while busy");
        check_eq(cs_n_o, 1'b1, "chip select idle");
    endtask

    initial begin
        lfsr_q   = 32'h43ff;
        arst_n_i = 1'b0;
        write_i  = 1'b0;
        read_i   = 1'b0;
        be_i     = '0;
        addr_i   = '0;
        wdata_i  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        #5;
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #5;
        test_registers();
        test_cmd_only();
        test_single_read();
        test_write(8'hA2, LANE_X2);
        test_write(8'h32, LANE_X4);
        test_quad_read_polled();
        test_busy_restart();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/qspi_pkg.sv
hdl/qspi_reg_file.sv
hdl/qspi_mem_arbiter.sv
hdl/qspi_sclk_gen.sv
hdl/qspi_shift_engine.sv
hdl/qspi_master.sv
tests/qspi_flash_model.sv
tests/tb_qspi_master.sv
